/* Makefile */
# Verilator build and run of the VGA controller testbench

VERILATOR ?= verilator
TOP       ?= tb_vga_controller
FILELIST  ?= vga_controller.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	-$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "PASS: $(TOP)"; \
	else \
		echo "FAIL: $(TOP), see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/frame_compositor.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_compositor import vga_pkg::*; (
	input  wire                VGA_CLK_n,
	input  wire                iRST_n,
	input  wire  [COORD_W-1:0] pix_x,
	input  wire  [COORD_W-1:0] pix_y,
	input  wire                active,
	input  wire                hs_raw,
	input  wire                vs_raw,
	input  wire  [COORD_W-1:0] p1_x,
	input  wire  [COORD_W-1:0] p1_y,
	input  wire  [COORD_W-1:0] p2_x,
	input  wire  [COORD_W-1:0] p2_y,
	input  wire                p1_lost,
	input  wire                p2_lost,
	input  wire                seg_hit,
	input  wire                lives1_hit,
	input  wire                lives2_hit,
	output logic [COLOR_W-1:0] color,
	output logic               hs,
	output logic               vs,
	output logic               blank_n
);

	function automatic logic in_player(input logic [COORD_W-1:0] px,
			input logic [COORD_W-1:0] py, input logic [COORD_W-1:0] ox,
			input logic [COORD_W-1:0] oy);
		int x;
		int y;
		x = int'(px) - int'(ox);
		y = int'(py) - int'(oy);
		return (x >= 0) && (x < PLAYER_SIZE) && (y >= 0) && (y < PLAYER_SIZE);
	endfunction

	logic               p1_hit;
	logic               p2_hit;
	logic [COLOR_W-1:0] next_color;

	assign p1_hit = in_player(pix_x, pix_y, p1_x, p1_y);
	assign p2_hit = in_player(pix_x, pix_y, p2_x, p2_y);

	always_comb begin
		if (lives2_hit)
			next_color = LIVES2_COLOR;
		else if (lives1_hit)
			next_color = LIVES1_COLOR;
		// End screen covers players and scores
		else if (p1_lost)
			next_color = END1_COLOR;
		else if (p2_lost)
			next_color = END2_COLOR;
		else if (p2_hit)
			next_color = P2_COLOR;
		else if (p1_hit)
			next_color = P1_COLOR;
		else if (seg_hit)
			next_color = SEG_COLOR;
		else
			next_color = BG_COLOR;
	end

	// Colour and sync leave together
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			color   <= '0;
			hs      <= 1'b1;
			vs      <= 1'b1;
			blank_n <= 1'b0;
		end else begin
			color   <= active ? next_color : '0;
			hs      <= hs_raw;
			vs      <= vs_raw;
			blank_n <= active;
		end
	end

endmodule

`default_nettype wire

/* design/lives_bar.sv */
`timescale 1ns/1ps
`default_nettype none

module lives_bar import vga_pkg::*; #(
	parameter int ORIGIN_X = P1_PANEL_X
) (
	input  wire [COORD_W-1:0] pix_x,
	input  wire [COORD_W-1:0] pix_y,
	input  wire [LIVES_N-1:0] lives,
	output logic              hit
);

	logic [LIVES_N-1:0] box_hit;
	int                 px;
	int                 py;
	logic               in_row;

	assign px = int'(pix_x);
	assign py = int'(pix_y);

	// All boxes share one row
	assign in_row = (py >= LIVES_Y) && (py < LIVES_Y + LIVES_BOX);

	for (genvar j = 0; j < LIVES_N; j++) begin : g_box
		localparam int BX = ORIGIN_X + j * LIVES_PITCH;

		logic in_col;

		assign in_col = (px >= BX) && (px < BX + LIVES_BOX);
		// Box j lit only while its bit is set
		assign box_hit[j] = lives[j] && in_col && in_row;
	end

	assign hit = |box_hit;

endmodule

`default_nettype wire

/* design/score_digits.sv */
`timescale 1ns/1ps
`default_nettype none

module score_digits import vga_pkg::*; #(
	parameter int ORIGIN_X = P1_PANEL_X
) (
	input  wire [COORD_W-1:0] pix_x,
	input  wire [COORD_W-1:0] pix_y,
	input  wire [SCORE_W-1:0] score,
	output logic              hit
);

	// Segment bits are {g, f, e, d, c, b, a}
	function automatic logic [6:0] seg_pattern(input logic [3:0] value);
		logic [6:0] pat;
		case (value)
			4'd0:    pat = 7'h3f;
			4'd1:    pat = 7'h06;
			4'd2:    pat = 7'h5b;
			4'd3:    pat = 7'h4f;
			4'd4:    pat = 7'h66;
			4'd5:    pat = 7'h6d;
			4'd6:    pat = 7'h7d;
			4'd7:    pat = 7'h07;
			4'd8:    pat = 7'h7f;
			4'd9:    pat = 7'h6f;
			default: pat = 7'h00;
		endcase
		return pat;
	endfunction

	function automatic logic in_rect(input int px, input int py, input int x0,
			input int y0, input int w, input int h);
		return (px >= x0) && (px < x0 + w) && (py >= y0) && (py < y0 + h);
	endfunction

	localparam int SEG_SIDE = SEG_LONG + SEG_THICK;
	localparam int RIGHT_X  = SEG_LONG - SEG_THICK;

	logic [SCORE_W-1:0] score_mod;
	logic [3:0]         digit [3];
	logic [2:0]         digit_hit;
	int                 px;
	int                 py;

	assign px = int'(pix_x);
	assign py = int'(pix_y);

	// Hundreds, tens, ones of the score modulo 1000
	always_comb begin
		score_mod = SCORE_W'(score % 1000);
		digit[0] = 4'(score_mod / 100);
		digit[1] = 4'((score_mod / 10) % 10);
		digit[2] = 4'(score_mod % 10);
	end

	for (genvar d = 0; d < 3; d++) begin : g_digit
		localparam int CX = ORIGIN_X + d * DIGIT_PITCH;

		logic [6:0] area;

		always_comb begin
			area[0] = in_rect(px, py, CX, PANEL_Y, SEG_LONG, SEG_THICK);
			area[1] = in_rect(px, py, CX + RIGHT_X, PANEL_Y, SEG_THICK, SEG_SIDE);
			area[2] = in_rect(px, py, CX + RIGHT_X, PANEL_Y + SEG_LONG,
				SEG_THICK, SEG_SIDE);
			area[3] = in_rect(px, py, CX, PANEL_Y + 2 * SEG_LONG, SEG_LONG, SEG_THICK);
			area[4] = in_rect(px, py, CX, PANEL_Y + SEG_LONG, SEG_THICK, SEG_SIDE);
			area[5] = in_rect(px, py, CX, PANEL_Y, SEG_THICK, SEG_SIDE);
			area[6] = in_rect(px, py, CX, PANEL_Y + SEG_LONG, SEG_LONG, SEG_THICK);
		end

		// Only lit segments count
		assign digit_hit[d] = |(area & seg_pattern(digit[d]));
	end

	assign hit = |digit_hit;

endmodule

`default_nettype wire

/* design/vga_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_controller import vga_pkg::*; #(
	parameter int H_ACTIVE = vga_pkg::H_ACTIVE,
	parameter int H_FRONT  = vga_pkg::H_FRONT,
	parameter int H_SYNC   = vga_pkg::H_SYNC,
	parameter int H_BACK   = vga_pkg::H_BACK,
	parameter int V_ACTIVE = vga_pkg::V_ACTIVE,
	parameter int V_FRONT  = vga_pkg::V_FRONT,
	parameter int V_SYNC   = vga_pkg::V_SYNC,
	parameter int V_BACK   = vga_pkg::V_BACK
) (
	input  wire                VGA_CLK_n,
	input  wire                iRST_n,
	input  wire  [COORD_W-1:0] p1_x,
	input  wire  [COORD_W-1:0] p1_y,
	input  wire  [COORD_W-1:0] p2_x,
	input  wire  [COORD_W-1:0] p2_y,
	input  wire  [SCORE_W-1:0] p1_score,
	input  wire  [SCORE_W-1:0] p2_score,
	input  wire  [LIVES_N-1:0] p1_lives,
	input  wire  [LIVES_N-1:0] p2_lives,
	output logic [7:0]         b_data,
	output logic [7:0]         g_data,
	output logic [7:0]         r_data,
	output logic               hs,
	output logic               vs,
	output logic               blank_n
);

	logic [COORD_W-1:0] pix_x;
	logic [COORD_W-1:0] pix_y;
	logic               active;
	logic               hs_raw;
	logic               vs_raw;
	logic               seg1_hit;
	logic               seg2_hit;
	logic               lives1_hit;
	logic               lives2_hit;
	logic [COLOR_W-1:0] color;

	vga_sync_gen #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) u_sync (
		.VGA_CLK_n, .iRST_n, .pix_x, .pix_y, .active, .hs_raw, .vs_raw
	);

	score_digits #(.ORIGIN_X(P1_PANEL_X)) u_score1 (
		.pix_x, .pix_y, .score(p1_score), .hit(seg1_hit)
	);

	score_digits #(.ORIGIN_X(P2_PANEL_X)) u_score2 (
		.pix_x, .pix_y, .score(p2_score), .hit(seg2_hit)
	);

	lives_bar #(.ORIGIN_X(P1_PANEL_X)) u_lives1 (
		.pix_x, .pix_y, .lives(p1_lives), .hit(lives1_hit)
	);

	lives_bar #(.ORIGIN_X(P2_PANEL_X)) u_lives2 (
		.pix_x, .pix_y, .lives(p2_lives), .hit(lives2_hit)
	);

	// A player with no lives left has lost
	frame_compositor u_comp (
		.VGA_CLK_n, .iRST_n, .pix_x, .pix_y, .active, .hs_raw, .vs_raw,
		.p1_x, .p1_y, .p2_x, .p2_y,
		.p1_lost(p1_lives == '0), .p2_lost(p2_lives == '0),
		.seg_hit(seg1_hit | seg2_hit), .lives1_hit, .lives2_hit,
		.color, .hs, .vs, .blank_n
	);

	assign b_data = color[23:16];
	assign g_data = color[15:8];
	assign r_data = color[7:0];

endmodule

`default_nettype wire

/* design/vga_pkg.sv */
`default_nettype none

package vga_pkg;

	// 640x480 at 800x525 total
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;

	localparam int COORD_W = 10;
	localparam int SCORE_W = 10;
	localparam int LIVES_N = 5;
	localparam int COLOR_W = 24;

	localparam int PLAYER_SIZE = 32;

	// Score panels
	localparam int P1_PANEL_X  = 40;
	localparam int P2_PANEL_X  = 400;
	localparam int PANEL_Y     = 20;
	localparam int DIGIT_PITCH = 30;
	localparam int SEG_LONG    = 25;
	localparam int SEG_THICK   = 5;

	// Lives row below each score
	localparam int LIVES_Y     = 80;
	localparam int LIVES_PITCH = 15;
	localparam int LIVES_BOX   = 10;

	// Colours as {blue, green, red}
	localparam logic [COLOR_W-1:0] BG_COLOR     = 24'h401810;
	localparam logic [COLOR_W-1:0] P1_COLOR     = 24'h0080ff;
	localparam logic [COLOR_W-1:0] P2_COLOR     = 24'hb469ff;
	localparam logic [COLOR_W-1:0] SEG_COLOR    = 24'hffffff;
	localparam logic [COLOR_W-1:0] LIVES1_COLOR = 24'h0000ff;
	localparam logic [COLOR_W-1:0] LIVES2_COLOR = 24'haaaaaa;
	localparam logic [COLOR_W-1:0] END1_COLOR   = 24'h00ffff;
	localparam logic [COLOR_W-1:0] END2_COLOR   = 24'hff0000;

endpackage

`default_nettype wire

/* design/vga_sync_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_sync_gen import vga_pkg::*; #(
	parameter int H_ACTIVE = vga_pkg::H_ACTIVE,
	parameter int H_FRONT  = vga_pkg::H_FRONT,
	parameter int H_SYNC   = vga_pkg::H_SYNC,
	parameter int H_BACK   = vga_pkg::H_BACK,
	parameter int V_ACTIVE = vga_pkg::V_ACTIVE,
	parameter int V_FRONT  = vga_pkg::V_FRONT,
	parameter int V_SYNC   = vga_pkg::V_SYNC,
	parameter int V_BACK   = vga_pkg::V_BACK
) (
	input  wire                VGA_CLK_n,
	input  wire                iRST_n,
	output logic [COORD_W-1:0] pix_x,
	output logic [COORD_W-1:0] pix_y,
	output logic               active,
	output logic               hs_raw,
	output logic               vs_raw
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam logic [COORD_W-1:0] H_LAST   = COORD_W'(H_TOTAL - 1);
	localparam logic [COORD_W-1:0] V_LAST   = COORD_W'(V_TOTAL - 1);
	localparam logic [COORD_W-1:0] H_VIS    = COORD_W'(H_ACTIVE);
	localparam logic [COORD_W-1:0] V_VIS    = COORD_W'(V_ACTIVE);
	localparam logic [COORD_W-1:0] HS_START = COORD_W'(H_ACTIVE + H_FRONT);
	localparam logic [COORD_W-1:0] HS_END   = COORD_W'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam logic [COORD_W-1:0] VS_START = COORD_W'(V_ACTIVE + V_FRONT);
	localparam logic [COORD_W-1:0] VS_END   = COORD_W'(V_ACTIVE + V_FRONT + V_SYNC);

	logic [COORD_W-1:0] h_cnt;
	logic [COORD_W-1:0] v_cnt;

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			// Frame wraps after the last line
			if (v_cnt == V_LAST)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Negative sync pulses from the same counter state
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			pix_x  <= '0;
			pix_y  <= '0;
			active <= 1'b0;
			hs_raw <= 1'b1;
			vs_raw <= 1'b1;
		end else begin
			pix_x  <= h_cnt;
			pix_y  <= v_cnt;
			active <= (h_cnt < H_VIS) && (v_cnt < V_VIS);
			hs_raw <= !((h_cnt >= HS_START) && (h_cnt < HS_END));
			vs_raw <= !((v_cnt >= VS_START) && (v_cnt < VS_END));
		end
	end

endmodule

`default_nettype wire

/* dv/tb_vga_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vga_controller import vga_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int TIMEOUT_CYCLES = 6 * H_TOTAL * V_TOTAL;

	// Bit n set when digit n lights the segment
	localparam int SEG_A = 'b1111101101;
	localparam int SEG_B = 'b1110011111;
	localparam int SEG_C = 'b1111111011;
	localparam int SEG_D = 'b1101101101;
	localparam int SEG_E = 'b0101000101;
	localparam int SEG_F = 'b1101110001;
	localparam int SEG_G = 'b1101111100;

	logic               VGA_CLK_n;
	logic               iRST_n;
	logic [COORD_W-1:0] p1_x;
	logic [COORD_W-1:0] p1_y;
	logic [COORD_W-1:0] p2_x;
	logic [COORD_W-1:0] p2_y;
	logic [SCORE_W-1:0] p1_score;
	logic [SCORE_W-1:0] p2_score;
	logic [LIVES_N-1:0] p1_lives;
	logic [LIVES_N-1:0] p2_lives;
	wire  [7:0]         b_data;
	wire  [7:0]         g_data;
	wire  [7:0]         r_data;
	wire                hs;
	wire                vs;
	wire                blank_n;

	logic [31:0]        rng = 32'hd8a;
	logic [COLOR_W-1:0] exp_color;
	int                 x = 0;
	int                 y = 0;
	int                 line_cycles = 0;
	int                 hs_low = 0;
	int                 frame_cycles = 0;
	int                 vs_low = 0;
	int                 cycle_count = 0;
	logic               hs_prev = 1'b1;
	logic               vs_prev = 1'b1;
	logic               seen_hs = 1'b0;
	logic               seen_vs = 1'b0;

	vga_controller UUT (
		.VGA_CLK_n, .iRST_n, .p1_x, .p1_y, .p2_x, .p2_y, .p1_score, .p2_score,
		.p1_lives, .p2_lives, .b_data, .g_data, .r_data, .hs, .vs, .blank_n
	);

	initial begin
		VGA_CLK_n = 1'b0;
		forever #(CLK_PERIOD / 2) VGA_CLK_n = ~VGA_CLK_n;
	end

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("Error: time %0t, %s expected %0d, got %0d", $time, name, exp, got);
			abort_run();
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic logic inside_box(input int px, input int py, input int x0,
			input int y0, input int w, input int h);
		return (px >= x0) && (px < x0 + w) && (py >= y0) && (py < y0 + h);
	endfunction

	function automatic logic segment_lit(input int px, input int py, input int org,
			input int score);
		int s;
		int dig;
		int rx;
		int ry;
		logic hit;
		hit = 1'b0;
		s = score % 1000;
		for (int d = 0; d < 3; d++) begin
			dig = (s / ((d == 0) ? 100 : (d == 1) ? 10 : 1)) % 10;
			rx = px - (org + d * DIGIT_PITCH);
			ry = py - PANEL_Y;
			hit |= ((SEG_A >> dig) & 1) != 0 && inside_box(rx, ry, 0, 0, 25, 5);
			hit |= ((SEG_B >> dig) & 1) != 0 && inside_box(rx, ry, 20, 0, 5, 30);
			hit |= ((SEG_C >> dig) & 1) != 0 && inside_box(rx, ry, 20, 25, 5, 30);
			hit |= ((SEG_D >> dig) & 1) != 0 && inside_box(rx, ry, 0, 50, 25, 5);
			hit |= ((SEG_E >> dig) & 1) != 0 && inside_box(rx, ry, 0, 25, 5, 30);
			hit |= ((SEG_F >> dig) & 1) != 0 && inside_box(rx, ry, 0, 0, 5, 30);
			hit |= ((SEG_G >> dig) & 1) != 0 && inside_box(rx, ry, 0, 25, 25, 5);
		end
		return hit;
	endfunction

	function automatic logic lives_box_lit(input int px, input int py, input int org,
			input int lives);
		logic hit;
		hit = 1'b0;
		for (int j = 0; j < LIVES_N; j++)
			hit |= ((lives >> j) & 1) != 0 &&
				inside_box(px, py, org + j * LIVES_PITCH, LIVES_Y, LIVES_BOX, LIVES_BOX);
		return hit;
	endfunction

	function automatic logic [COLOR_W-1:0] ref_color(input int px, input int py);
		logic [COLOR_W-1:0] c;
		if (lives_box_lit(px, py, P2_PANEL_X, int'(p2_lives)))
			c = LIVES2_COLOR;
		else if (lives_box_lit(px, py, P1_PANEL_X, int'(p1_lives)))
			c = LIVES1_COLOR;
		else if (p1_lives == '0)
			c = END1_COLOR;
		else if (p2_lives == '0)
			c = END2_COLOR;
		else if (inside_box(px, py, int'(p2_x), int'(p2_y), PLAYER_SIZE, PLAYER_SIZE))
			c = P2_COLOR;
		else if (inside_box(px, py, int'(p1_x), int'(p1_y), PLAYER_SIZE, PLAYER_SIZE))
			c = P1_COLOR;
		else if (segment_lit(px, py, P1_PANEL_X, int'(p1_score)) ||
				segment_lit(px, py, P2_PANEL_X, int'(p2_score)))
			c = SEG_COLOR;
		else
			c = BG_COLOR;
		return c;
	endfunction

	function automatic logic [LIVES_N-1:0] random_lives();
		logic [LIVES_N-1:0] l;
		l = LIVES_N'(next_random());
		if (l == '0)
			l = 5'b10101;
		return l;
	endfunction

	task automatic load_random_frame();
		p1_x = COORD_W'(next_random() % H_ACTIVE);
		p1_y = COORD_W'(next_random() % V_ACTIVE);
		p2_x = COORD_W'(next_random() % H_ACTIVE);
		p2_y = COORD_W'(next_random() % V_ACTIVE);
		p1_score = SCORE_W'(next_random() % 1024);
		p2_score = SCORE_W'(next_random() % 1024);
		p1_lives = random_lives();
		p2_lives = random_lives();
	endtask

	// Returns 2 ns after the edge that shows vs falling
	task automatic wait_frame_end();
		do begin
			@(posedge VGA_CLK_n);
			#2;
		end while (!vs);
		do begin
			@(posedge VGA_CLK_n);
			#2;
		end while (vs);
	endtask

	initial begin
		iRST_n = 1'b1;
		// Overlapping players over p1's lives row and score
		p1_x = 10'd50;
		p1_y = 10'd70;
		p2_x = 10'd65;
		p2_y = 10'd78;
		p1_score = 10'd7;
		p2_score = 10'd999;
		p1_lives = 5'b11011;
		p2_lives = 5'b10101;
		#1 iRST_n = 1'b0;
		#4;
		check_value("hs after reset", int'(hs), 1);
		check_value("vs after reset", int'(vs), 1);
		check_value("blank_n after reset", int'(blank_n), 0);
		check_value("color after reset", int'({b_data, g_data, r_data}), 0);
		repeat (2) @(posedge VGA_CLK_n);
		#2 iRST_n = 1'b1;
		wait_frame_end();
		load_random_frame();
		p1_score = 10'd0;
		wait_frame_end();
		load_random_frame();
		wait_frame_end();
		load_random_frame();
		p1_lives = '0;
		wait_frame_end();
		load_random_frame();
		p2_lives = '0;
		wait_frame_end();
		$display("Test OK");
		$finish;
	end

	// Outputs sampled on the falling edge midway between updates
	always @(negedge VGA_CLK_n) begin
		if (blank_n) begin
			exp_color = ref_color(x, y);
			assert ({b_data, g_data, r_data} == exp_color) else begin
				$display("Error: time %0t, color at x %0d y %0d expected %h, got %h",
					$time, x, y, exp_color, {b_data, g_data, r_data});
				abort_run();
			end
			x++;
		end else begin
			check_value("color while blanked", int'({b_data, g_data, r_data}), 0);
		end
		if (hs_prev && !hs) begin
			if (seen_hs)
				check_value("hs period", line_cycles, H_TOTAL);
			if (x != 0) begin
				check_value("blank_n high cycles in line", x, H_ACTIVE);
				y++;
			end
			seen_hs = 1'b1;
			line_cycles = 0;
			x = 0;
		end
		if (!hs_prev && hs) begin
			check_value("hs low cycles", hs_low, H_SYNC);
			hs_low = 0;
		end
		if (vs_prev && !vs) begin
			if (seen_vs)
				check_value("vs period", frame_cycles, H_TOTAL * V_TOTAL);
			check_value("active lines in frame", y, V_ACTIVE);
			seen_vs = 1'b1;
			frame_cycles = 0;
			y = 0;
		end
		if (!vs_prev && vs) begin
			check_value("vs low cycles", vs_low, V_SYNC * H_TOTAL);
			vs_low = 0;
		end
		if (!hs)
			hs_low++;
		if (!vs)
			vs_low++;
		line_cycles++;
		frame_cycles++;
		hs_prev = hs;
		vs_prev = vs;
	end

	always @(posedge VGA_CLK_n) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout: frame sequence not finished after %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

endmodule

`default_nettype wire

/* vga_controller.f */
design/vga_pkg.sv
design/vga_sync_gen.sv
design/score_digits.sv
design/lives_bar.sv
design/frame_compositor.sv
design/vga_controller.sv
dv/tb_vga_controller.sv
